//--- lcdTimingPkg.sv
//////////////////////////////////////////////////
// LCD panel timing definitions
// Sync/DE timing of the 800x480 panel and the sync and position types
//////////////////////////////////////////////////
package lcdTimingPkg;

    // Visible area
    localparam int activeWidth  = 800;
    localparam int activeHeight = 480;

    // Horizontal timing in pixel clocks with the pulse inside the back porch
    localparam int hBackPorch  = 182;
    localparam int hPulse      = 1;
    localparam int hFrontPorch = 210;
    localparam int hTotal      = activeWidth + hBackPorch + hFrontPorch;

    // Vertical timing in lines
    localparam int vBackPorch  = 6;
    localparam int vPulse      = 5;
    localparam int vFrontPorch = 45;
    localparam int vTotal      = activeHeight + vBackPorch + vFrontPorch;

    // Counter widths follow from the periods
    localparam int hCntW = $clog2(hTotal);
    localparam int vCntW = $clog2(vTotal);

    typedef logic [hCntW-1:0] hCountT;
    typedef logic [vCntW-1:0] vCountT;

    // Terminal counts where the counters wrap
    localparam hCountT hLast = hCountT'(hTotal - 1);
    localparam vCountT vLast = vCountT'(vTotal - 1);

    // Active column and row
    typedef logic [10:0] xT;
    typedef logic [9:0]  yT;

    // Both syncs are active low
    typedef struct packed {
        logic hSync;
        logic vSync;
        logic de;
    } syncT;

    typedef struct packed {
        xT x;
        yT y;
    } posT;

endpackage

//--- lcdPixelPkg.sv
//////////////////////////////////////////////////
// LCD pixel definitions
// RGB565 pixel format, test-pattern modes and the colour-bar palette
//////////////////////////////////////////////////
package lcdPixelPkg;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565T;

    typedef enum logic [1:0] {
        patBars    = 2'd0,
        patSolid   = 2'd1,
        patChecker = 2'd2
    } patternModeT;

    // Sixteen bars of 50 pixels fill the 800 pixel line
    localparam int barWidth = 50;
    localparam int barCount = 16;
    localparam int barIdxW  = $clog2(barCount);

    typedef logic [barIdxW-1:0] barIdxT;

    // Checker squares are a power of two so one position bit picks the square
    localparam int checkerSize = 32;
    localparam int checkerBit  = $clog2(checkerSize);

    // Red and green ramp up while blue ramps down
    localparam rgb565T barColour [barCount] = '{
        '{5'd0,  6'd0,  5'd31},
        '{5'd2,  6'd4,  5'd29},
        '{5'd4,  6'd8,  5'd27},
        '{5'd6,  6'd12, 5'd25},
        '{5'd8,  6'd16, 5'd23},
        '{5'd10, 6'd20, 5'd21},
        '{5'd12, 6'd24, 5'd19},
        '{5'd14, 6'd28, 5'd17},
        '{5'd16, 6'd32, 5'd15},
        '{5'd18, 6'd36, 5'd13},
        '{5'd20, 6'd40, 5'd11},
        '{5'd22, 6'd44, 5'd9},
        '{5'd24, 6'd48, 5'd7},
        '{5'd26, 6'd52, 5'd5},
        '{5'd28, 6'd56, 5'd3},
        '{5'd30, 6'd60, 5'd1}
    };

endpackage

//--- lcdTiming.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// LCD timing generator
// Pixel and line counters decoded into registered sync, DE,
// active position and a frame-start pulse
//////////////////////////////////////////////////
module lcdTiming (
    input  logic               PixelClk,
    input  logic               nRST,
    output lcdTimingPkg::syncT sync,
    output lcdTimingPkg::posT  pos,
    output logic               frameStart
);

    lcdTimingPkg::hCountT hCount;
    lcdTimingPkg::vCountT vCount;
    lcdTimingPkg::hCountT hNext;
    lcdTimingPkg::vCountT vNext;
    logic                 hActive;
    logic                 vActive;
    logic                 deNext;

    // The outputs are decoded from the next count so they change on the
    // same edge as the counters themselves
    always_comb begin
        if (hCount == lcdTimingPkg::hLast) begin
            hNext = '0;
            if (vCount == lcdTimingPkg::vLast) begin
                vNext = '0;
            end else begin
                vNext = vCount + 1'b1;
            end
        end else begin
            hNext = hCount + 1'b1;
            vNext = vCount;
        end
    end

    assign hActive = (hNext >= lcdTimingPkg::hBackPorch) &&
                     (hNext < lcdTimingPkg::hBackPorch + lcdTimingPkg::activeWidth);
    assign vActive = (vNext >= lcdTimingPkg::vBackPorch) &&
                     (vNext < lcdTimingPkg::vBackPorch + lcdTimingPkg::activeHeight);
    assign deNext  = hActive && vActive;

    // Reset parks the counters on the last pixel of a frame, so the first
    // edge out of reset opens frame zero with a frame-start pulse
    always_ff @(posedge PixelClk or negedge nRST) begin
        if (!nRST) begin
            hCount <= lcdTimingPkg::hLast;
            vCount <= lcdTimingPkg::vLast;
        end else begin
            hCount <= hNext;
            vCount <= vNext;
        end
    end

    always_ff @(posedge PixelClk or negedge nRST) begin
        if (!nRST) begin
            sync       <= '{hSync: 1'b1, vSync: 1'b1, de: 1'b0};
            frameStart <= 1'b0;
        end else begin
            sync.hSync <= (hNext >= lcdTimingPkg::hPulse);
            sync.vSync <= (vNext >= lcdTimingPkg::vPulse);
            sync.de    <= deNext;
            frameStart <= (hNext == '0) && (vNext == '0);
        end
    end

    // Position is relative to the top left active pixel and held at zero
    // in the blanking intervals
    always_ff @(posedge PixelClk or negedge nRST) begin
        if (!nRST) begin
            pos <= '0;
        end else if (deNext) begin
            pos.x <= lcdTimingPkg::xT'(hNext - lcdTimingPkg::hBackPorch);
            pos.y <= lcdTimingPkg::yT'(vNext - lcdTimingPkg::vBackPorch);
        end else begin
            pos <= '0;
        end
    end

endmodule

//--- patternGen.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// Test-pattern generator
// Colour bars, solid colour or checkerboard, with the mode held per frame
//////////////////////////////////////////////////
module patternGen (
    input  logic                     PixelClk,
    input  logic                     nRST,
    input  lcdTimingPkg::syncT       sync,
    input  lcdTimingPkg::posT        pos,
    input  logic                     frameStart,
    input  lcdPixelPkg::patternModeT mode,
    input  lcdPixelPkg::rgb565T      solidColour,
    output lcdTimingPkg::syncT       pixSync,
    output lcdPixelPkg::rgb565T      pixel,
    output logic                     pixFrameStart
);

    lcdPixelPkg::patternModeT modeQ;
    lcdPixelPkg::rgb565T      solidQ;
    lcdPixelPkg::barIdxT      barIdx;
    logic                     checkerOn;
    lcdPixelPkg::rgb565T      colour;

    // Selections only move at the frame boundary so a frame is never torn
    always_ff @(posedge PixelClk or negedge nRST) begin
        if (!nRST) begin
            modeQ  <= lcdPixelPkg::patBars;
            solidQ <= '0;
        end else if (frameStart) begin
            modeQ  <= mode;
            solidQ <= solidColour;
        end
    end

    assign barIdx    = lcdPixelPkg::barIdxT'(pos.x / lcdPixelPkg::barWidth);
    assign checkerOn = pos.x[lcdPixelPkg::checkerBit] ^ pos.y[lcdPixelPkg::checkerBit];

    always_comb begin
        case (modeQ)
            lcdPixelPkg::patBars: begin
                colour = lcdPixelPkg::barColour[barIdx];
            end
            lcdPixelPkg::patSolid: begin
                colour = solidQ;
            end
            lcdPixelPkg::patChecker: begin
                colour = checkerOn ? '1 : '0;
            end
            default: begin
                colour = '0;
            end
        endcase
    end

    // Sync and frame start are delayed by one cycle to stay with the colour
    always_ff @(posedge PixelClk or negedge nRST) begin
        if (!nRST) begin
            pixSync       <= '{hSync: 1'b1, vSync: 1'b1, de: 1'b0};
            pixFrameStart <= 1'b0;
            pixel         <= '0;
        end else begin
            pixSync       <= sync;
            pixFrameStart <= frameStart;
            if (sync.de) begin
                pixel <= colour;
            end else begin
                pixel <= '0;
            end
        end
    end

endmodule

//--- lcdOutStage.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// LCD output stage
// Registers sync, DE and data onto the panel pins with frame-aligned blanking
//////////////////////////////////////////////////
module lcdOutStage (
    input  logic                PixelClk,
    input  logic                nRST,
    input  lcdTimingPkg::syncT  pixSync,
    input  lcdPixelPkg::rgb565T pixel,
    input  logic                pixFrameStart,
    input  logic                blank,
    output logic                lcdHSync,
    output logic                lcdVSync,
    output logic                lcdDe,
    output lcdPixelPkg::rgb565T lcdData
);

    logic blankQ;

    // Blank takes effect at the next frame
    always_ff @(posedge PixelClk or negedge nRST) begin
        if (!nRST) begin
            blankQ <= 1'b0;
        end else if (pixFrameStart) begin
            blankQ <= blank;
        end
    end

    // The syncs keep running while blanked so the panel stays locked
    always_ff @(posedge PixelClk or negedge nRST) begin
        if (!nRST) begin
            lcdHSync <= 1'b1;
            lcdVSync <= 1'b1;
            lcdDe    <= 1'b0;
            lcdData  <= '0;
        end else begin
            lcdHSync <= pixSync.hSync;
            lcdVSync <= pixSync.vSync;
            lcdDe    <= pixSync.de;
            if (blankQ) begin
                lcdData <= '0;
            end else begin
                lcdData <= pixel;
            end
        end
    end

endmodule

//--- lcdPanelTop.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// LCD panel driver top level
// Timing generator, pattern generator and pin output stage in a chain
//////////////////////////////////////////////////
module lcdPanelTop (
    input  logic                     PixelClk,
    input  logic                     nRST,
    input  lcdPixelPkg::patternModeT mode,
    input  lcdPixelPkg::rgb565T      solidColour,
    input  logic                     blank,
    output logic                     lcdHSync,
    output logic                     lcdVSync,
    output logic                     lcdDe,
    output lcdPixelPkg::rgb565T      lcdData
);

    lcdTimingPkg::syncT  sync;
    lcdTimingPkg::posT   pos;
    logic                frameStart;
    lcdTimingPkg::syncT  pixSync;
    lcdPixelPkg::rgb565T pixel;
    logic                pixFrameStart;

    lcdTiming timing (
        .PixelClk   (PixelClk),
        .nRST       (nRST),
        .sync       (sync),
        .pos        (pos),
        .frameStart (frameStart)
    );

    patternGen pattern (
        .PixelClk      (PixelClk),
        .nRST          (nRST),
        .sync          (sync),
        .pos           (pos),
        .frameStart    (frameStart),
        .mode          (mode),
        .solidColour   (solidColour),
        .pixSync       (pixSync),
        .pixel         (pixel),
        .pixFrameStart (pixFrameStart)
    );

    lcdOutStage outStage (
        .PixelClk      (PixelClk),
        .nRST          (nRST),
        .pixSync       (pixSync),
        .pixel         (pixel),
        .pixFrameStart (pixFrameStart),
        .blank         (blank),
        .lcdHSync      (lcdHSync),
        .lcdVSync      (lcdVSync),
        .lcdDe         (lcdDe),
        .lcdData       (lcdData)
    );

endmodule

//--- tbLcdPanel.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// LCD panel driver testbench
// Checks sync timing, DE window, patterns and frame-aligned switching
//////////////////////////////////////////////////
module tbLcdPanel;

    localparam int frameCycles  = lcdTimingPkg::hTotal * lcdTimingPkg::vTotal;
    localparam int frameTimeout = 2 * frameCycles;

    logic                     PixelClk;
    logic                     nRST;
    lcdPixelPkg::patternModeT mode;
    lcdPixelPkg::rgb565T      solidColour;
    logic                     blank;
    logic                     lcdHSync;
    logic                     lcdVSync;
    logic                     lcdDe;
    lcdPixelPkg::rgb565T      lcdData;

    // Reference model state is measured at the pins
    int  cyc = 0;
    int  rstSamples = 0;
    bit  seenSync = 0;
    bit  prevH = 1;
    bit  prevV = 1;
    bit  prevDe = 0;
    int  hLow = 0;
    int  vLow = 0;
    bit  haveHFall = 0;
    bit  haveVFall = 0;
    int  lastHFall = 0;
    int  lastVFall = 0;
    int  hPos = 0;
    int  lineNo = 0;
    int  deCnt = 0;
    int  deLines = 0;
    int  frames = 0;
    lcdPixelPkg::patternModeT frameMode = lcdPixelPkg::patBars;
    lcdPixelPkg::rgb565T      frameSolid = '0;
    bit                       frameBlank = 0;

    int errorCount = 0;
    int testsPassed = 0;
    int testsFailed = 0;
    int testErrStart = 0;
    bit timedOut = 0;

    lcdPanelTop uut (
        .PixelClk    (PixelClk),
        .nRST        (nRST),
        .mode        (mode),
        .solidColour (solidColour),
        .blank       (blank),
        .lcdHSync    (lcdHSync),
        .lcdVSync    (lcdVSync),
        .lcdDe       (lcdDe),
        .lcdData     (lcdData)
    );

    initial begin
        PixelClk = 1'b0;
        forever #4 PixelClk = ~PixelClk;
    end

    task automatic reportMismatch(input string name, input int expected, input int actual);
        errorCount++;
        $display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
    endtask

    task automatic endRun();
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 testsPassed, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    // Expected colour straight from the pattern rules
    function automatic lcdPixelPkg::rgb565T expectedColour(input int x, input int y,
            input lcdPixelPkg::patternModeT m, input lcdPixelPkg::rgb565T solid,
            input bit blanked);
        int                  bar;
        lcdPixelPkg::rgb565T c;
        bar = x / lcdPixelPkg::barWidth;
        c = '0;
        if (!blanked) begin
            case (m)
                lcdPixelPkg::patBars: begin
                    c.r = 5'(2 * bar);
                    c.g = 6'(4 * bar);
                    c.b = 5'(31 - 2 * bar);
                end
                lcdPixelPkg::patSolid: begin
                    c = solid;
                end
                lcdPixelPkg::patChecker: begin
                    if (((x / lcdPixelPkg::checkerSize) % 2) !=
                        ((y / lcdPixelPkg::checkerSize) % 2)) begin
                        c = '1;
                    end
                end
                default: begin
                    c = '0;
                end
            endcase
        end
        return c;
    endfunction

    task automatic checkIdle();
        assert (lcdHSync === 1'b1) else reportMismatch("lcdHSync", 1, lcdHSync);
        assert (lcdVSync === 1'b1) else reportMismatch("lcdVSync", 1, lcdVSync);
        assert (lcdDe === 1'b0) else reportMismatch("lcdDe", 0, lcdDe);
        assert (lcdData === '0) else reportMismatch("lcdData", 0, lcdData);
    endtask

    dataIdle: assert property (@(posedge PixelClk) disable iff (!nRST)
        !lcdDe |-> lcdData == '0)
        else reportMismatch("lcdData outside DE", 0, $sampled(lcdData));

    always @(posedge PixelClk) begin : monitor
        bit                  hFall;
        bit                  vFall;
        lcdPixelPkg::rgb565T expected;
        if (!nRST) begin
            // The first edge in reset only loads the reset values
            rstSamples++;
            if (rstSamples > 1) begin
                checkIdle();
            end
        end else begin
            cyc++;
            hFall = prevH && !lcdHSync;
            vFall = prevV && !lcdVSync;
            if (hFall || vFall) begin
                seenSync = 1;
            end
            if (!seenSync) begin
                checkIdle();
            end
            if (hFall) begin
                hLow = 1;
            end else if (!lcdHSync) begin
                hLow++;
            end
            if (!prevH && lcdHSync) begin
                assert (hLow == lcdTimingPkg::hPulse)
                    else reportMismatch("lcdHSync low cycles", lcdTimingPkg::hPulse, hLow);
            end
            if (vFall) begin
                vLow = 1;
            end else if (!lcdVSync) begin
                vLow++;
            end
            if (!prevV && lcdVSync) begin
                assert (vLow == lcdTimingPkg::vPulse * lcdTimingPkg::hTotal)
                    else reportMismatch("lcdVSync low cycles",
                                        lcdTimingPkg::vPulse * lcdTimingPkg::hTotal, vLow);
            end
            // Line end is handled before frame end since both fall together
            if (hFall) begin
                if (haveHFall) begin
                    assert (cyc - lastHFall == lcdTimingPkg::hTotal)
                        else reportMismatch("lcdHSync period", lcdTimingPkg::hTotal,
                                            cyc - lastHFall);
                end
                if (deCnt != 0) begin
                    assert (deCnt == lcdTimingPkg::activeWidth)
                        else reportMismatch("lcdDe cycles per line",
                                            lcdTimingPkg::activeWidth, deCnt);
                    deLines++;
                end
                haveHFall = 1;
                lastHFall = cyc;
                hPos = 0;
                deCnt = 0;
                lineNo++;
            end else begin
                hPos++;
            end
            if (vFall) begin
                if (haveVFall) begin
                    assert (cyc - lastVFall == frameCycles)
                        else reportMismatch("lcdVSync period", frameCycles, cyc - lastVFall);
                    assert (deLines == lcdTimingPkg::activeHeight)
                        else reportMismatch("lcdDe lines per frame",
                                            lcdTimingPkg::activeHeight, deLines);
                end
                haveVFall = 1;
                lastVFall = cyc;
                deLines = 0;
                lineNo = 0;
                frames++;
                // Inputs only change mid-frame, so these are what the DUT latched
                frameMode = mode;
                frameSolid = solidColour;
                frameBlank = blank;
            end
            if (lcdDe) begin
                if (deCnt == 0) begin
                    assert (hPos == lcdTimingPkg::hBackPorch)
                        else reportMismatch("lcdDe start after lcdHSync",
                                            lcdTimingPkg::hBackPorch, hPos);
                    assert (lineNo == lcdTimingPkg::vBackPorch + deLines)
                        else reportMismatch("lcdDe line number",
                                            lcdTimingPkg::vBackPorch + deLines, lineNo);
                end else begin
                    assert (prevDe) else reportMismatch("lcdDe previous cycle", 1, prevDe);
                end
                expected = expectedColour(deCnt, deLines, frameMode, frameSolid, frameBlank);
                assert (lcdData == expected) else reportMismatch("lcdData", expected, lcdData);
                deCnt++;
            end
        end
        prevH = nRST ? lcdHSync : 1'b1;
        prevV = nRST ? lcdVSync : 1'b1;
        prevDe = nRST ? lcdDe : 1'b0;
    end

    task automatic waitFrame(input int target);
        int count;
        count = 0;
        while (!timedOut && frames < target) begin
            @(posedge PixelClk);
            count++;
            if (count > frameTimeout) begin
                $display("timeout: frame %0d did not start within %0d cycles",
                         target, frameTimeout);
                errorCount++;
                timedOut = 1;
            end
        end
    endtask

    task automatic waitLines(input int target);
        int count;
        count = 0;
        while (!timedOut && deLines < target) begin
            @(posedge PixelClk);
            count++;
            if (count > frameTimeout) begin
                $display("timeout: active line %0d never reached", target);
                errorCount++;
                timedOut = 1;
            end
        end
    endtask

    task automatic startTest();
        testErrStart = errorCount;
    endtask

    task automatic endTest(input string name);
        if (errorCount == testErrStart) begin
            testsPassed++;
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", name, errorCount - testErrStart);
        end
    endtask

    initial begin
        logic [31:0] rnd;
        void'($urandom(32'h248));
        nRST <= 1'b0;
        mode <= lcdPixelPkg::patBars;
        solidColour <= '0;
        blank <= 1'b0;
        repeat (3) @(posedge PixelClk);
        nRST <= 1'b1;

        startTest();
        waitFrame(1);
        endTest("reset state");

        // Every change lands halfway down the active area
        startTest();
        waitLines(240);
        @(posedge PixelClk);
        mode <= lcdPixelPkg::patChecker;
        waitFrame(2);
        endTest("colour bars, checker selected mid-frame");

        startTest();
        waitLines(240);
        rnd = $urandom();
        @(posedge PixelClk);
        mode <= lcdPixelPkg::patSolid;
        solidColour <= rnd[15:0];
        waitFrame(3);
        endTest("checker, solid selected mid-frame");

        startTest();
        waitLines(240);
        rnd = $urandom();
        @(posedge PixelClk);
        solidColour <= rnd[15:0];
        blank <= 1'b1;
        waitFrame(4);
        endTest("solid, new colour and blank mid-frame");

        startTest();
        waitLines(240);
        @(posedge PixelClk);
        blank <= 1'b0;
        waitFrame(5);
        endTest("blanked frame, blank lowered mid-frame");

        startTest();
        waitFrame(6);
        endTest("solid after blanking");

        endRun();
    end

endmodule

//--- sim.f
lcdTimingPkg.sv
lcdPixelPkg.sv
lcdTiming.sv
patternGen.sv
lcdOutStage.sv
lcdPanelTop.sv
tbLcdPanel.sv

//--- Makefile
# Verilator build and run of the LCD panel driver testbench

LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tbLcdPanel -f sim.f -o Vsim
	./obj_dir/Vsim | tee $(LOG)
	grep -q "^>>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
